// File: gfx_pkg.sv
// framebuffer geometry, coordinate and colour widths
// host command word (line or palette entry) and default palette
package gfx_pkg;

    // framebuffer
    localparam int fb_width  = 32;                     // pixels
    localparam int fb_height = 24;                     // pixels
    localparam int fb_pixels = fb_width * fb_height;   // 768
    localparam int fb_addrw  = $clog2(fb_pixels);      // 10 bits

    // coordinates and colour
    localparam int cordw = 8;          // signed coordinate width
    localparam int cidxw = 4;          // colour index, bits per pixel
    localparam int chanw = 4;          // per channel
    localparam int colrw = 3 * chanw;  // r, g, b
    localparam int errw  = cordw + 3;  // bresenham error, full-range lines

    localparam int lat_addr = 3;  // bitmap_addr pipeline depth
    localparam int cmdw     = 40; // host command word

    typedef struct packed {
        logic [chanw-1:0] r;
        logic [chanw-1:0] g;
        logic [chanw-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic signed [cordw-1:0] x;
        logic signed [cordw-1:0] y;
    } point_t;

    // draw a line in colour index cidx
    typedef struct packed {
        logic [cmdw-4*cordw-cidxw-1:0] pad;
        logic signed [cordw-1:0]       x0;
        logic signed [cordw-1:0]       y0;
        logic signed [cordw-1:0]       x1;
        logic signed [cordw-1:0]       y1;
        logic [cidxw-1:0]              cidx;
    } line_cmd_t;

    // load one palette entry
    typedef struct packed {
        logic [cmdw-cidxw-colrw-1:0] pad;
        logic [cidxw-1:0]            idx;
        rgb_t                        colr;
    } pal_cmd_t;

    // same 40 bits, meaning picked by cmd_kind
    typedef union packed {
        line_cmd_t line;
        pal_cmd_t  pal;
    } cmd_word_t;

    // sweetie 16, reduced to 4 bits per channel
    localparam rgb_t default_palette [2**cidxw] = '{
        12'h123, 12'h525, 12'hb35, 12'he75,
        12'hfc7, 12'haf7, 12'h3b6, 12'h277,
        12'h236, 12'h35c, 12'h4af, 12'h7ef,
        12'hfff, 12'h9bc, 12'h578, 12'h335
    };

endpackage

// File: draw_line.sv
// bresenham line stepper
// emits one point per cycle, endpoints inclusive, then a done pulse
module draw_line import gfx_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_sys,
    input  logic      start,    // new line, only taken when idle
    input  line_cmd_t cmd,
    output point_t    pt,       // current point
    output logic      drawing,  // pt is valid
    output logic      busy,
    output logic      done      // cycle after last point
);

    logic active;  // walking the line

    // endpoints widened so differences cannot overflow
    logic signed [errw-1:0] x0_w, y0_w, x1_w, y1_w;
    logic signed [errw-1:0] dx_in, dy_in;

    // latched line parameters
    logic signed [errw-1:0]  dx;      // always >= 0
    logic signed [errw-1:0]  dy;      // always <= 0
    logic signed [errw-1:0]  err;
    logic signed [cordw-1:0] inc_x;   // +1 or -1
    logic signed [cordw-1:0] inc_y;
    point_t                  pt_end;

    // per-step decision
    logic signed [errw:0]   e2;
    logic                   mv_x, mv_y;
    logic signed [errw-1:0] err_next;
    logic                   last;

    always_comb begin
        x0_w  = cmd.x0;  // sign extends
        y0_w  = cmd.y0;
        x1_w  = cmd.x1;
        y1_w  = cmd.y1;
        dx_in = (x1_w >= x0_w) ? x1_w - x0_w : x0_w - x1_w;  // |x1-x0|
        dy_in = (y1_w >= y0_w) ? y0_w - y1_w : y1_w - y0_w;  // -|y1-y0|
    end

    always_comb begin
        e2   = err + err;
        mv_x = (e2 >= dy);  // ties step
        mv_y = (e2 <= dx);
        err_next = err;
        if (mv_x) err_next = err_next + dy;
        if (mv_y) err_next = err_next + dx;  // both when diagonal
        last = (pt == pt_end);
    end

    always_ff @(posedge clk_sys) begin
        done <= 1'b0;
        if (!active) begin
            if (start) begin
                active <= 1'b1;
                pt.x   <= cmd.x0;  // first point shows next cycle
                pt.y   <= cmd.y0;
                pt_end <= '{x: cmd.x1, y: cmd.y1};
                inc_x  <= (cmd.x1 >= cmd.x0) ? cordw'(1) : -cordw'(1);
                inc_y  <= (cmd.y1 >= cmd.y0) ? cordw'(1) : -cordw'(1);
                dx     <= dx_in;
                dy     <= dy_in;
                err    <= dx_in + dy_in;
            end
        end else if (last) begin
            active <= 1'b0;  // end point already shown
            done   <= 1'b1;
        end else begin
            err <= err_next;
            if (mv_x) pt.x <= pt.x + inc_x;
            if (mv_y) pt.y <= pt.y + inc_y;
        end
        if (rst_sys) begin
            active <= 1'b0;
            done   <= 1'b0;
        end
    end

    assign drawing = active;
    assign busy    = active;  // low again in the done cycle

endmodule

// File: bitmap_addr.sv
// coordinate to framebuffer address, three cycles
// clip set when the point lies off the framebuffer
module bitmap_addr import gfx_pkg::*; (
    input  logic                clk_sys,
    input  point_t              pt,
    output logic [fb_addrw-1:0] addr,  // y * fb_width + x
    output logic                clip   // off screen, do not write
);

    // stage 1
    logic [cordw-1:0]    x_s1;     // raw bits, only used when on screen
    logic [cordw-1:0]    y_s1;
    logic                clip_s1;

    // stage 2
    logic [cordw-1:0]    x_s2;
    logic [fb_addrw-1:0] row_s2;   // start of row
    logic                clip_s2;

    always_ff @(posedge clk_sys) begin
        // bounds check on signed coordinates
        clip_s1 <= (pt.x < 0) || (pt.x >= fb_width)
                || (pt.y < 0) || (pt.y >= fb_height);
        x_s1 <= pt.x;
        y_s1 <= pt.y;
    end

    always_ff @(posedge clk_sys) begin
        row_s2  <= fb_addrw'(y_s1) * fb_addrw'(fb_width);  // constant multiply
        x_s2    <= x_s1;
        clip_s2 <= clip_s1;
    end

    always_ff @(posedge clk_sys) begin
        addr <= row_s2 + fb_addrw'(x_s2);  // garbage when clipped
        clip <= clip_s2;
    end

endmodule

// File: fb_bram.sv
// framebuffer memory, one write port and one read port
// cleared at configuration, registered read
module fb_bram import gfx_pkg::*; (
    input  logic                clk_sys,
    input  logic                we,
    input  logic [fb_addrw-1:0] addr_write,
    input  logic [cidxw-1:0]    data_in,    // colour index
    input  logic [fb_addrw-1:0] addr_read,
    output logic [cidxw-1:0]    data_out
);

    logic [cidxw-1:0] mem [fb_pixels];

    initial begin
        for (int i = 0; i < fb_pixels; i++) begin
            mem[i] = '0;  // blank screen, palette entry 0
        end
    end

    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_write] <= data_in;
        data_out <= mem[addr_read];  // old data on same-address collision
    end

endmodule

// File: clut.sv
// colour lookup table, 16 entries of 12-bit colour
// host write port, registered read for scan-out
module clut import gfx_pkg::*; (
    input  logic             clk_sys,
    input  logic             we,          // palette load
    input  logic [cidxw-1:0] cidx_write,
    input  rgb_t             colr_in,
    input  logic [cidxw-1:0] cidx_read,   // from framebuffer
    output rgb_t             colr_out
);

    rgb_t mem [2**cidxw];

    initial begin
        for (int i = 0; i < 2**cidxw; i++) begin
            mem[i] = default_palette[i];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (we) mem[cidx_write] <= colr_in;
    end

    always_ff @(posedge clk_sys) begin
        colr_out <= mem[cidx_read];  // one cycle
    end

endmodule

// File: fb_scanout.sv
// linear framebuffer reader
// streams every pixel once as a valid-marked colour
module fb_scanout import gfx_pkg::*; (
    input  logic                clk_sys,
    input  logic                rst_sys,
    input  logic                scan_start,  // ignored mid-scan
    output logic [fb_addrw-1:0] addr_read,   // to framebuffer
    input  rgb_t                colr,        // from clut, two cycles later
    output rgb_t                pix,
    output logic                pix_valid
);

    logic       scanning;  // addr_read is live
    logic [1:0] vld_sr;    // bram then clut latency

    // address counter
    always_ff @(posedge clk_sys) begin
        if (!scanning) begin
            if (scan_start) begin
                scanning  <= 1'b1;
                addr_read <= '0;
            end
        end else begin
            if (addr_read == fb_addrw'(fb_pixels-1)) begin
                scanning <= 1'b0;  // last address issued
            end else begin
                addr_read <= addr_read + 1'b1;
            end
        end
        if (rst_sys) begin
            scanning  <= 1'b0;
            addr_read <= '0;
        end
    end

    // valid follows data through memory and palette
    always_ff @(posedge clk_sys) begin
        vld_sr    <= {vld_sr[0], scanning};
        pix_valid <= vld_sr[1];
        if (rst_sys) begin
            vld_sr    <= '0;
            pix_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        pix <= colr;  // output register
    end

endmodule

// File: gfx_top.sv
// graphics engine top: command decode, line drawing into framebuffer
// write enable alignment, palette and scan-out
module gfx_top import gfx_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_sys,
    input  logic      cmd_valid,   // command strobe
    input  logic      cmd_kind,    // 0 line, 1 palette
    input  cmd_word_t cmd,
    input  logic      scan_start,
    output logic      busy,        // line in progress
    output logic      done,        // line finished
    output rgb_t      pix,
    output logic      pix_valid
);

    logic line_start;  // line requested
    logic pal_we;      // palette load, always taken

    always_comb begin
        line_start = cmd_valid && !cmd_kind;
        pal_we     = cmd_valid && cmd_kind;
    end

    // colour for the whole line, latched on acceptance
    logic [cidxw-1:0] cidx_line;
    always_ff @(posedge clk_sys) begin
        if (line_start && !busy) cidx_line <= cmd.line.cidx;
    end

    // line stepper
    point_t pt;
    logic   drawing;
    draw_line draw_line_inst (
        .clk_sys,
        .rst_sys,
        .start(line_start),  // dropped inside while busy
        .cmd(cmd.line),
        .pt,
        .drawing,
        .busy,
        .done
    );

    // point to address, lat_addr cycles
    logic [fb_addrw-1:0] fb_addr_write;
    logic                fb_clip;
    bitmap_addr bitmap_addr_inst (
        .clk_sys,
        .pt,
        .addr(fb_addr_write),
        .clip(fb_clip)
    );

    // drawing and colour delayed to meet the address
    logic [lat_addr-1:0] fb_we_sr;
    logic [cidxw-1:0]    cidx_sr [lat_addr];  // last points of a line keep their colour
    logic                fb_we;

    always_ff @(posedge clk_sys) begin
        fb_we_sr <= {drawing, fb_we_sr[lat_addr-1:1]};
        if (rst_sys) fb_we_sr <= '0;
    end

    always_ff @(posedge clk_sys) begin
        cidx_sr[lat_addr-1] <= cidx_line;
        for (int i = 0; i < lat_addr-1; i++) begin
            cidx_sr[i] <= cidx_sr[i+1];
        end
    end

    assign fb_we = fb_we_sr[0] && !fb_clip;  // off-screen points never written

    // framebuffer
    logic [fb_addrw-1:0] fb_addr_read;
    logic [cidxw-1:0]    fb_cidx_read;
    fb_bram fb_bram_inst (
        .clk_sys,
        .we(fb_we),
        .addr_write(fb_addr_write),
        .data_in(cidx_sr[0]),
        .addr_read(fb_addr_read),
        .data_out(fb_cidx_read)
    );

    // palette, written straight from the command word
    rgb_t clut_colr;
    clut clut_inst (
        .clk_sys,
        .we(pal_we),
        .cidx_write(cmd.pal.idx),
        .colr_in(cmd.pal.colr),
        .cidx_read(fb_cidx_read),
        .colr_out(clut_colr)
    );

    // scan-out
    fb_scanout fb_scanout_inst (
        .clk_sys,
        .rst_sys,
        .scan_start,
        .addr_read(fb_addr_read),
        .colr(clut_colr),
        .pix,
        .pix_valid
    );

endmodule

// File: tb_gfx_model.sv
// reference model for the graphics engine testbench
// framebuffer and palette model, bresenham rule, value check
package tb_gfx_model;
    import gfx_pkg::*;

    int error_count = 0;  // all failed checks and timeouts

    logic [cidxw-1:0] fb_model [fb_pixels];  // colour index per pixel
    logic [colrw-1:0] pal_model [16];

    // clut contents at configuration
    localparam logic [colrw-1:0] boot_palette [16] = '{
        12'h123, 12'h525, 12'hb35, 12'he75, 12'hfc7, 12'haf7, 12'h3b6, 12'h277,
        12'h236, 12'h35c, 12'h4af, 12'h7ef, 12'hfff, 12'h9bc, 12'h578, 12'h335
    };

    function automatic void reset_model();
        for (int a = 0; a < fb_pixels; a++) fb_model[a] = '0;  // blank frame
        for (int i = 0; i < 16; i++) pal_model[i] = boot_palette[i];
    endfunction

    function automatic void set_palette(input int idx, input logic [colrw-1:0] colr);
        pal_model[idx] = colr;
    endfunction

    // off-screen points are dropped
    function automatic void plot(input int x, input int y, input int cidx);
        if (x >= 0 && x < fb_width && y >= 0 && y < fb_height) begin
            fb_model[y * fb_width + x] = cidx[cidxw-1:0];
        end
    endfunction

    // integer bresenham, both endpoints drawn, returns point count
    function automatic int render_line(input int x0, input int y0, input int x1,
                                       input int y1, input int cidx);
        int dx, dy, sx, sy, err, e2, x, y, npts;
        dx   = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy   = (y1 > y0) ? y0 - y1 : y1 - y0;  // kept negative
        sx   = (x0 < x1) ? 1 : -1;
        sy   = (y0 < y1) ? 1 : -1;
        err  = dx + dy;
        x    = x0;
        y    = y0;
        npts = 0;
        while (1) begin
            plot(x, y, cidx);
            npts++;
            if (x == x1 && y == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin  // tie moves
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin  // both on a diagonal step
                err += dx;
                y   += sy;
            end
        end
        return npts;
    endfunction

    function automatic logic [colrw-1:0] pixel_colour(input int addr);
        return pal_model[fb_model[addr]];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

endpackage

// File: tb_gfx.sv
// testbench for gfx_top: clock, reset, case file reader
// line and palette stimulus, full-frame scan capture against the model
module tb_gfx import gfx_pkg::*, tb_gfx_model::*; ();

    localparam int timeout_cycles = 2000;  // per wait loop
    localparam int scan_lat       = 3;     // bram, clut, output register

    logic      clk_sys = 1'b0;
    logic      rst_sys;
    logic      cmd_valid;
    logic      cmd_kind;
    cmd_word_t cmd;
    logic      scan_start;
    logic      busy, done, pix_valid;
    rgb_t      pix;

    logic [colrw-1:0] scan_pix [fb_pixels];  // last captured frame
    int               exp_x [$];             // listed pixels of the test
    int               exp_y [$];
    logic [colrw-1:0] exp_c [$];
    string            test_name;
    int               test_base;             // error count at test start
    int               tests_run = 0;
    int               tests_bad = 0;

    gfx_top dut0 (
        .clk_sys, .rst_sys, .cmd_valid, .cmd_kind, .cmd, .scan_start,
        .busy, .done, .pix, .pix_valid
    );

    always #20 clk_sys = ~clk_sys;

    task automatic begin_test(input string name);
        test_name = name;
        test_base = error_count;
        exp_x.delete();
        exp_y.delete();
        exp_c.delete();
    endtask

    task automatic end_test();
        int errs;
        errs = error_count - test_base;
        tests_run++;
        if (errs != 0) tests_bad++;
        $display("test %-12s errors %0d", test_name, errs);
    endtask

    // write on the next edge
    task automatic send_palette(input int idx, input logic [colrw-1:0] colr);
        cmd          = '0;
        cmd.pal.idx  = idx[cidxw-1:0];
        cmd.pal.colr = colr;
        cmd_kind     = 1'b1;
        cmd_valid    = 1'b1;
        @(negedge clk_sys);
        cmd_valid = 1'b0;
        cmd_kind  = 1'b0;
        set_palette(idx, colr);
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (busy && t < timeout_cycles) begin
            @(negedge clk_sys);
            t++;
        end
        if (busy) begin
            $display("timeout in test %s: busy never went low", test_name);
            error_count++;
        end
    endtask

    // background lines return right after the strobe
    task automatic send_line(input int x0, input int y0, input int x1, input int y1,
                             input int cidx, input bit background);
        bit accepted;
        bit got_done;
        int npts, busy_cnt, t;
        accepted      = !busy;  // dropped while a line runs
        cmd           = '0;
        cmd.line.x0   = x0[cordw-1:0];
        cmd.line.y0   = y0[cordw-1:0];
        cmd.line.x1   = x1[cordw-1:0];
        cmd.line.y1   = y1[cordw-1:0];
        cmd.line.cidx = cidx[cidxw-1:0];
        cmd_kind      = 1'b0;
        cmd_valid     = 1'b1;
        npts          = accepted ? render_line(x0, y0, x1, y1, cidx) : 0;
        busy_cnt      = 0;
        got_done      = 1'b0;
        t             = 0;
        if (accepted && !background) begin
            while (!got_done && t < timeout_cycles) begin
                @(negedge clk_sys);
                cmd_valid = 1'b0;
                t++;
                if (done) got_done = 1'b1;
                else if (busy) busy_cnt++;  // one cycle per point
            end
            if (!got_done) begin
                $display("timeout in test %s: no done pulse after a line", test_name);
                error_count++;
            end else begin
                check_value("busy_cycles", busy_cnt, npts);
                check_value("busy", busy, 0);  // already low with done
                @(negedge clk_sys);
                check_value("done", done, 0);  // single pulse
            end
        end else begin
            @(negedge clk_sys);
            cmd_valid = 1'b0;
            if (!accepted && !background) wait_idle();  // let the running line end
        end
    endtask

    task automatic compare_frame();
        int a;
        for (a = 0; a < fb_pixels; a++) begin
            check_value($sformatf("pix[%0d,%0d]", a % fb_width, a / fb_width),
                        scan_pix[a], pixel_colour(a));
        end
        foreach (exp_c[i]) begin
            a = exp_y[i] * fb_width + exp_x[i];
            check_value($sformatf("pix[%0d,%0d] listed", exp_x[i], exp_y[i]),
                        scan_pix[a], exp_c[i]);
        end
    endtask

    task automatic run_scan();
        int lat, n;
        wait_idle();
        repeat (4) @(negedge clk_sys);  // drain the address pipeline
        scan_start = 1'b1;
        lat        = 0;
        while (!pix_valid && lat <= timeout_cycles) begin
            @(negedge clk_sys);
            scan_start = 1'b0;
            lat++;
        end
        if (!pix_valid) begin
            $display("timeout in test %s: pix_valid never rose after scan_start", test_name);
            error_count++;
        end else begin
            check_value("scan_latency", lat - 1, scan_lat);  // count starts before the edge
            n = 0;
            while (pix_valid && n < fb_pixels + 16) begin
                if (n < fb_pixels) scan_pix[n] = pix;
                n++;
                @(negedge clk_sys);
            end
            check_value("pix_valid_cycles", n, fb_pixels);
            compare_frame();
        end
    endtask

    // mixed lines and palette loads, only the model knows the result
    task automatic random_test();
        int x0, y0, x1, y1;
        begin_test("random");
        for (int i = 0; i < 24; i++) begin
            if ($urandom_range(3, 0) == 0) begin
                send_palette($urandom_range(15, 0), 12'($urandom_range(4095, 0)));
            end else begin
                x0 = int'($urandom_range(47, 0)) - 8;  // partly off screen
                y0 = int'($urandom_range(39, 0)) - 8;
                x1 = int'($urandom_range(47, 0)) - 8;
                y1 = int'($urandom_range(39, 0)) - 8;
                send_line(x0, y0, x1, y1, $urandom_range(15, 0), 1'b0);
            end
        end
        run_scan();
        end_test();
    endtask

    initial begin
        int               fd, code, idx, x0, y0, x1, y1, cidx, px, py;
        logic [colrw-1:0] colr;
        string            tok, name, rest;
        void'($urandom(32'h7804_9625));
        rst_sys    = 1'b1;
        cmd_valid  = 1'b0;
        cmd_kind   = 1'b0;
        cmd        = '0;
        scan_start = 1'b0;
        reset_model();
        repeat (10) @(negedge clk_sys);
        rst_sys = 1'b0;

        begin_test("reset_state");
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        check_value("pix_valid", pix_valid, 0);
        end_test();

        fd = $fopen("gfx_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file gfx_cases.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) break;
                case (tok)
                    "#": code = $fgets(rest, fd);  // comment line
                    "T": begin
                        code = $fscanf(fd, "%s", name);
                        begin_test(name);
                    end
                    "P": begin
                        code = $fscanf(fd, "%d %h", idx, colr);
                        send_palette(idx, colr);
                    end
                    "L", "B": begin
                        code = $fscanf(fd, "%d %d %d %d %d", x0, y0, x1, y1, cidx);
                        send_line(x0, y0, x1, y1, cidx, tok == "B");
                    end
                    "E": begin
                        code = $fscanf(fd, "%d %d %h", px, py, colr);
                        exp_x.push_back(px);
                        exp_y.push_back(py);
                        exp_c.push_back(colr);
                    end
                    "S": begin
                        run_scan();
                        end_test();
                    end
                    default: begin
                        $display("unknown record %s in the case file", tok);
                        error_count++;
                    end
                endcase
            end
            $fclose(fd);
        end

        random_test();

        $display("tests %0d, tests with errors %0d, errors %0d",
                 tests_run, tests_bad, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: gfx_cases.txt
# T name | P idx rgb | L x0 y0 x1 y1 cidx (B = same, not waited for) | E x y rgb
# S scans the frame and checks it; rgb values are hex
T reset
E 0 0 123
E 31 23 123
S
T lines
L 0 0 31 0 1
L 5 2 5 20 2
L 0 0 23 23 3
L 30 1 8 23 4
L 10 10 10 10 5
L 2 3 17 9 6
E 31 0 525
E 0 0 e75
E 5 2 b35
E 5 20 b35
E 23 23 e75
E 30 1 fc7
E 8 23 fc7
E 10 10 af7
E 2 3 3b6
E 17 9 3b6
S
T clip
L -5 -3 40 12 7
L -10 30 -1 40 8
L 20 -20 20 30 9
E 20 0 35c
E 20 23 35c
S
T palette
P 9 f00
B 0 12 31 12 10
P 10 0f0
E 20 0 f00
E 0 12 0f0
E 31 12 0f0
S
T busy
B 0 20 31 20 11
L 0 5 31 5 12
L 0 18 31 18 13
L 15 10 15 23 14
E 0 20 7ef
E 0 5 123
E 31 5 123
E 14 18 9bc
E 15 18 578
E 15 20 578
S

// File: build.f
gfx_pkg.sv
draw_line.sv
bitmap_addr.sv
fb_bram.sv
clut.sv
fb_scanout.sv
gfx_top.sv
tb_gfx_model.sv
tb_gfx.sv

// File: Bender.yml
package:
  name: gfx_engine

sources:
  - gfx_pkg.sv
  - draw_line.sv
  - bitmap_addr.sv
  - fb_bram.sv
  - clut.sv
  - fb_scanout.sv
  - gfx_top.sv
  - target: test
    files:
      - tb_gfx_model.sv
      - tb_gfx.sv
